// ==== hdl/intcPkg.sv ====
package intcPkg;

	// source count is fixed by the IPRA/IPRB register map
	localparam int NUM_IRQ = 8;

	typedef logic [3:0] prioLevel_t;
	typedef logic [7:0] vector_t;
	typedef logic [3:0] apbAddr_t;
	typedef logic [31:0] apbData_t;
	typedef logic [15:0] intReg_t;
	typedef logic [NUM_IRQ-1:0] irqBus_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_REQUEST
	} arbState_t;

	// byte offsets inside the APB window
	localparam apbAddr_t IPRA_OFFSET = 4'h0;
	localparam apbAddr_t IPRB_OFFSET = 4'h4;
	localparam apbAddr_t ICR_OFFSET = 4'h8;

	// NMIE selects the rising edge of the NMI pin when set
	localparam int ICR_NMIE_BIT = 8;

	localparam intReg_t IPR_WMASK = 16'hFFFF;
	localparam intReg_t ICR_WMASK = 16'h0100;
	localparam intReg_t REG_RESET = 16'h0000;

	// NMI always wins and sits above every maskable level
	localparam prioLevel_t NMI_LEVEL = 4'd15;
	localparam vector_t NMI_VECTOR = 8'd11;

	// IRQ i is taken through vector IRQ_VECTOR_BASE + i
	localparam vector_t IRQ_VECTOR_BASE = 8'd64;

endpackage

// ==== hdl/nmiDetect.sv ====
`timescale 1ns/1ps

module nmiDetect (
	input  logic CLK,
	input  logic RST_N,
	input  logic nmiN,
	input  logic nmiRisingEdge,
	input  logic nmiClear,
	output logic nmiReq
);

	logic sync0;
	logic sync1;
	logic prev;
	logic edgeSeen;

	// the pin idles high, so the stages start high to avoid a false edge out of reset
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			sync0 <= 1'b1;
			sync1 <= 1'b1;
			prev <= 1'b1;
		end else begin
			sync0 <= nmiN;
			sync1 <= sync0;
			prev <= sync1;
		end
	end

	assign edgeSeen = nmiRisingEdge ? (sync1 && !prev) : (!sync1 && prev);

	// a new edge is only taken while no request is outstanding
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			nmiReq <= 1'b0;
		end else if (!nmiReq && edgeSeen) begin
			nmiReq <= 1'b1;
		end else if (nmiClear) begin
			nmiReq <= 1'b0;
		end
	end

	// the request is only withdrawn by the arbiter once it has been acknowledged
	nmiHeldUntilClear: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(nmiReq) |-> $past(nmiClear));

endmodule

// ==== hdl/irqFilter.sv ====
`timescale 1ns/1ps

module irqFilter (
	input  logic             CLK,
	input  logic             RST_N,
	input  intcPkg::irqBus_t irqN,
	output intcPkg::irqBus_t irqReq
);

	import intcPkg::*;

	// pins are active low, so every stage holds the inverted pin level
	irqBus_t sync0;
	irqBus_t sync1;
	irqBus_t history;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			sync0 <= '0;
			sync1 <= '0;
			history <= '0;
		end else begin
			sync0 <= ~irqN;
			sync1 <= sync0;
			history <= sync1;
		end
	end

	// two consecutive low samples are needed
	// a single-cycle low glitch never shows up in both stages at once
	assign irqReq = sync1 & history;

endmodule

// ==== hdl/intcRegs.sv ====
`timescale 1ns/1ps

module intcRegs (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  intcPkg::apbAddr_t paddr,
	input  intcPkg::apbData_t pwdata,
	output intcPkg::apbData_t prdata,
	output logic              pready,
	output logic              pslverr,
	output intcPkg::intReg_t  ipra,
	output intcPkg::intReg_t  iprb,
	output logic              nmiRisingEdge
);

	import intcPkg::*;

	intReg_t icr;
	intReg_t wrData;
	logic access;
	logic selIpra;
	logic selIprb;
	logic selIcr;
	logic mapped;

	// read-only bits keep their value, writable bits take the new data
	function automatic intReg_t maskedWrite(intReg_t cur, intReg_t wr, intReg_t mask);
		return (wr & mask) | (cur & ~mask);
	endfunction

	assign access = psel && penable;
	assign wrData = pwdata[15:0];

	assign selIpra = (paddr == IPRA_OFFSET);
	assign selIprb = (paddr == IPRB_OFFSET);
	assign selIcr = (paddr == ICR_OFFSET);
	assign mapped = selIpra || selIprb || selIcr;

	// zero wait states on every access
	assign pready = 1'b1;
	assign pslverr = access && !mapped;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ipra <= REG_RESET;
			iprb <= REG_RESET;
			icr <= REG_RESET;
		end else if (access && pwrite) begin
			if (selIpra) begin
				ipra <= maskedWrite(ipra, wrData, IPR_WMASK);
			end
			if (selIprb) begin
				iprb <= maskedWrite(iprb, wrData, IPR_WMASK);
			end
			if (selIcr) begin
				icr <= maskedWrite(icr, wrData, ICR_WMASK);
			end
		end
	end

	// registers sit in the low half word, the upper half always reads zero
	always_comb begin
		prdata = '0;
		if (selIpra) begin
			prdata = {16'h0000, ipra};
		end else if (selIprb) begin
			prdata = {16'h0000, iprb};
		end else if (selIcr) begin
			prdata = {16'h0000, icr};
		end
	end

	assign nmiRisingEdge = icr[ICR_NMIE_BIT];

	// an error is only reported in the access phase of a properly started transfer
	slvErrInAccess: assert property (@(posedge CLK) disable iff (!RST_N)
		pslverr |-> psel && penable && $past(psel && !penable));

endmodule

// ==== hdl/intArbiter.sv ====
`timescale 1ns/1ps

module intArbiter (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                nmiReq,
	input  intcPkg::irqBus_t    irqReq,
	input  intcPkg::intReg_t    ipra,
	input  intcPkg::intReg_t    iprb,
	input  intcPkg::prioLevel_t cpuMask,
	input  logic                intAck,
	output logic                intReq,
	output intcPkg::prioLevel_t intLevel,
	output intcPkg::vector_t    intVector,
	output logic                nmiClear
);

	import intcPkg::*;

	arbState_t state;
	logic winnerNmi;

	prioLevel_t irqPrio [NUM_IRQ];
	logic grantValid;
	prioLevel_t grantLevel;
	vector_t grantVector;

	// IRQ0 and IRQ4 sit in the top nibble of their register
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			irqPrio[i] = ipra[15 - 4*i -: 4];
			irqPrio[i + 4] = iprb[15 - 4*i -: 4];
		end
	end

	// NMI goes first, then IRQ0 up to IRQ7 in fixed order
	// the IRQ loop runs downwards so the lowest eligible number is left standing
	always_comb begin
		grantValid = 1'b0;
		grantLevel = '0;
		grantVector = '0;
		if (nmiReq) begin
			grantValid = 1'b1;
			grantLevel = NMI_LEVEL;
			grantVector = NMI_VECTOR;
		end else begin
			for (int i = NUM_IRQ - 1; i >= 0; i--) begin
				if (irqReq[i] && (irqPrio[i] > cpuMask)) begin
					grantValid = 1'b1;
					grantLevel = irqPrio[i];
					grantVector = vector_t'(IRQ_VECTOR_BASE + i);
				end
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ARB_IDLE;
			winnerNmi <= 1'b0;
			intLevel <= '0;
			intVector <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (grantValid) begin
						state <= ARB_REQUEST;
						winnerNmi <= nmiReq;
						intLevel <= grantLevel;
						intVector <= grantVector;
					end
				end
				ARB_REQUEST: begin
					// the CPU may hold off the acknowledge for as long as it likes
					if (intAck) begin
						state <= ARB_IDLE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	assign intReq = (state == ARB_REQUEST);

	// NMI detector drops its request at the same edge that ends the hand-off
	assign nmiClear = (state == ARB_REQUEST) && intAck && winnerNmi;

	// level and vector seen by the CPU do not move while the request is held
	reqPayloadStable: assert property (@(posedge CLK) disable iff (!RST_N)
		intReq && $past(intReq) |-> $stable(intLevel) && $stable(intVector));

	// a request is only withdrawn by an acknowledge taken in the request state
	ackOnlyInRequest: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(intReq) |-> $past(intAck && state == ARB_REQUEST));

endmodule

// ==== hdl/intcTop.sv ====
`timescale 1ns/1ps

module intcTop (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  intcPkg::apbAddr_t   paddr,
	input  intcPkg::apbData_t   pwdata,
	output intcPkg::apbData_t   prdata,
	output logic                pready,
	output logic                pslverr,
	input  logic                nmiN,
	input  intcPkg::irqBus_t    irqN,
	input  intcPkg::prioLevel_t cpuMask,
	input  logic                intAck,
	output logic                intReq,
	output intcPkg::prioLevel_t intLevel,
	output intcPkg::vector_t    intVector
);

	import intcPkg::*;

	logic nmiReq;
	logic nmiClear;
	logic nmiRisingEdge;
	irqBus_t irqReq;
	intReg_t ipra;
	intReg_t iprb;

	nmiDetect nmiDetect_i (
		.CLK           (CLK),
		.RST_N         (RST_N),
		.nmiN          (nmiN),
		.nmiRisingEdge (nmiRisingEdge),
		.nmiClear      (nmiClear),
		.nmiReq        (nmiReq)
	);

	irqFilter irqFilter_i (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.irqN   (irqN),
		.irqReq (irqReq)
	);

	intcRegs intcRegs_i (
		.CLK           (CLK),
		.RST_N         (RST_N),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.ipra          (ipra),
		.iprb          (iprb),
		.nmiRisingEdge (nmiRisingEdge)
	);

	intArbiter intArbiter_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.nmiReq    (nmiReq),
		.irqReq    (irqReq),
		.ipra      (ipra),
		.iprb      (iprb),
		.cpuMask   (cpuMask),
		.intAck    (intAck),
		.intReq    (intReq),
		.intLevel  (intLevel),
		.intVector (intVector),
		.nmiClear  (nmiClear)
	);

endmodule

// ==== tests/intcTb.sv ====
`timescale 1ns/1ps

module intcTb;

	import intcPkg::*;

	localparam int REQ_TIMEOUT = 20;
	localparam int QUIET_WINDOW = 20;
	localparam int QUARTER = 2;
	localparam logic [31:0] SEED = 32'hf1e7_3d23;

	typedef enum {ACT_WRITE, ACT_READ, ACT_PINS, ACT_ACK} action_t;
	typedef enum {CHK_NONE, CHK_REQ, CHK_QUIET} reqCheck_t;

	// target is the APB offset for bus rows and {nmiN, irqN} for pin rows
	typedef struct {
		string      name;
		action_t    act;
		logic [8:0] target;
		apbData_t   data;
		prioLevel_t mask;
		apbData_t   expData;
		logic       expErr;
		reqCheck_t  chk;
		prioLevel_t expLevel;
		vector_t    expVector;
	} row_t;

	logic CLK;
	logic RST_N;
	logic psel;
	logic penable;
	logic pwrite;
	apbAddr_t paddr;
	apbData_t pwdata;
	apbData_t prdata;
	logic pready;
	logic pslverr;
	logic nmiN;
	irqBus_t irqN;
	prioLevel_t cpuMask;
	logic intAck;
	logic intReq;
	prioLevel_t intLevel;
	vector_t intVector;

	row_t rows[$];

	intcTop dut_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.nmiN      (nmiN),
		.irqN      (irqN),
		.cpuMask   (cpuMask),
		.intAck    (intAck),
		.intReq    (intReq),
		.intLevel  (intLevel),
		.intVector (intVector)
	);

	always #4 CLK = ~CLK;

	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// IRQ i is taken through vector 64 + i
	function automatic vector_t irqVector(input int i);
		return 8'd64 + 8'(i);
	endfunction

	function automatic void addRow(input string name, input action_t act,
			input logic [8:0] target, input apbData_t data, input prioLevel_t mask,
			input apbData_t expData, input logic expErr, input reqCheck_t chk,
			input prioLevel_t lvl, input vector_t vec);
		row_t r;
		r = '{name, act, target, data, mask, expData, expErr, chk, lvl, vec};
		rows.push_back(r);
	endfunction

	function automatic void buildTable();
		logic [31:0] seed;
		logic [15:0] val;
		prioLevel_t nib;
		logic [8:0] pinsLow;
		int k;
		seed = SEED;
		// register block after reset, then an unmapped offset
		addRow("rstIpra", ACT_READ, 9'h000, '0, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("rstIprb", ACT_READ, 9'h004, '0, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("rstIcr", ACT_READ, 9'h008, '0, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("badRead", ACT_READ, 9'h00C, '0, 4'd0, '0, 1'b1, CHK_NONE, 4'd0, 8'd0);
		addRow("badWrite", ACT_WRITE, 9'h00C, '1, 4'd0, '0, 1'b1, CHK_NONE, 4'd0, 8'd0);
		addRow("icrAllOnes", ACT_WRITE, 9'h008, '1, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("icrReadback", ACT_READ, 9'h008, '0, 4'd0, 32'h100, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("icrClear", ACT_WRITE, 9'h008, '0, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("ipraWrite", ACT_WRITE, 9'h000, 32'h7654, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("ipraReadback", ACT_READ, 9'h000, '0, 4'd0, 32'h7654, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("iprbWrite", ACT_WRITE, 9'h004, 32'h3BC2, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("iprbReadback", ACT_READ, 9'h004, '0, 4'd0, 32'h3BC2, 1'b0, CHK_NONE, 4'd0, 8'd0);
		// single IRQ sources above the mask
		addRow("irq1Low", ACT_PINS, 9'h1FD, '0, 4'd2, '0, 1'b0, CHK_REQ, 4'd6, irqVector(1));
		addRow("irq1Release", ACT_PINS, 9'h1FF, '0, 4'd2, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("irq1Ack", ACT_ACK, 9'h1FF, '0, 4'd2, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		addRow("irq6Low", ACT_PINS, 9'h1BF, '0, 4'd2, '0, 1'b0, CHK_REQ, 4'd12, irqVector(6));
		addRow("irq6Release", ACT_PINS, 9'h1FF, '0, 4'd2, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("irq6Ack", ACT_ACK, 9'h1FF, '0, 4'd2, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		// fields at or below the mask stay silent until raised
		addRow("irq7Masked", ACT_PINS, 9'h17F, '0, 4'd4, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		addRow("irq3AtMask", ACT_PINS, 9'h1F7, '0, 4'd4, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		addRow("irq3Raised", ACT_WRITE, 9'h000, 32'h7659, 4'd4, '0, 1'b0, CHK_REQ, 4'd9,
			irqVector(3));
		addRow("irq3Release", ACT_PINS, 9'h1FF, '0, 4'd4, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("irq3Ack", ACT_ACK, 9'h1FF, '0, 4'd4, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		// fixed order between pending sources
		addRow("irq2And5Low", ACT_PINS, 9'h1DB, '0, 4'd0, '0, 1'b0, CHK_REQ, 4'd5, irqVector(2));
		addRow("irq2Release", ACT_PINS, 9'h1DF, '0, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("irq2Ack", ACT_ACK, 9'h1DF, '0, 4'd0, '0, 1'b0, CHK_REQ, 4'd11, irqVector(5));
		addRow("irq5Release", ACT_PINS, 9'h1FF, '0, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("irq5Ack", ACT_ACK, 9'h1FF, '0, 4'd0, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		addRow("nmiAndIrq0", ACT_PINS, 9'h0FE, '0, 4'd0, '0, 1'b0, CHK_REQ, 4'd15, 8'd11);
		addRow("nmiAck", ACT_ACK, 9'h0FE, '0, 4'd0, '0, 1'b0, CHK_REQ, 4'd7, irqVector(0));
		addRow("nmiIrq0Release", ACT_PINS, 9'h1FF, '0, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("irq0Ack", ACT_ACK, 9'h1FF, '0, 4'd0, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		// NMI edge selection under the top mask, which NMI ignores
		addRow("nmiFall", ACT_PINS, 9'h0FF, '0, 4'd15, '0, 1'b0, CHK_REQ, 4'd15, 8'd11);
		addRow("nmiFallAck", ACT_ACK, 9'h0FF, '0, 4'd15, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		addRow("nmiRiseIgnored", ACT_PINS, 9'h1FF, '0, 4'd15, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		addRow("nmieSet", ACT_WRITE, 9'h008, 32'h100, 4'd15, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		addRow("nmiFallIgnored", ACT_PINS, 9'h0FF, '0, 4'd15, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		addRow("nmiRise", ACT_PINS, 9'h1FF, '0, 4'd15, '0, 1'b0, CHK_REQ, 4'd15, 8'd11);
		addRow("nmiRiseAck", ACT_ACK, 9'h1FF, '0, 4'd15, '0, 1'b0, CHK_QUIET, 4'd0, 8'd0);
		addRow("nmieClear", ACT_WRITE, 9'h008, '0, 4'd0, '0, 1'b0, CHK_NONE, 4'd0, 8'd0);
		// random IPRB images with the mask one below the chosen field
		for (int n = 0; n < 3; n++) begin
			seed = nextRandom(seed);
			k = 4 + int'(seed[1:0]);
			val = seed[31:16];
			nib = val[31 - 4*k -: 4];
			if (nib == 4'd0) begin
				nib = 4'd1;
				val[31 - 4*k -: 4] = nib;
			end
			pinsLow = 9'h1FF & ~(9'h001 << k);
			addRow($sformatf("rand%0dWrite", n), ACT_WRITE, 9'h004, {16'h0000, val}, 4'd0, '0,
				1'b0, CHK_NONE, 4'd0, 8'd0);
			addRow($sformatf("rand%0dRead", n), ACT_READ, 9'h004, '0, 4'd0, {16'h0000, val},
				1'b0, CHK_NONE, 4'd0, 8'd0);
			addRow($sformatf("rand%0dIrq%0d", n, k), ACT_PINS, pinsLow, '0, nib - 4'd1, '0,
				1'b0, CHK_REQ, nib, irqVector(k));
			addRow($sformatf("rand%0dRelease", n), ACT_PINS, 9'h1FF, '0, nib - 4'd1, '0, 1'b0,
				CHK_NONE, 4'd0, 8'd0);
			addRow($sformatf("rand%0dAck", n), ACT_ACK, 9'h1FF, '0, nib - 4'd1, '0, 1'b0,
				CHK_QUIET, 4'd0, 8'd0);
		end
	endfunction

	task automatic stopRun(input string line);
		$display("TEST FAIL");
		$display("%s", line);
		$fatal(1, "stopped at the first failed check");
	endtask

	task automatic reportMismatch(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		stopRun($sformatf("error: %s %s expected 0x%0h actual 0x%0h", name, what, expected,
			actual));
	endtask

	// setup cycle, then the access cycle; outputs are read a quarter period into it
	task automatic apbTransfer(input logic write, input apbAddr_t addr, input apbData_t wdata,
			output apbData_t rdata, output logic err, output logic ready);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge CLK);
		penable = 1'b1;
		#QUARTER;
		rdata = prdata;
		err = pslverr;
		ready = pready;
		@(negedge CLK);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic expectRequest(input row_t r);
		int cycles;
		cycles = 0;
		while (intReq !== 1'b1 && cycles < REQ_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		assert (intReq === 1'b1)
		else stopRun($sformatf("%s: no interrupt request within %0d cycles", r.name,
			REQ_TIMEOUT));
		assert (intLevel === r.expLevel)
		else reportMismatch(r.name, "intLevel", 32'(r.expLevel), 32'(intLevel));
		assert (intVector === r.expVector)
		else reportMismatch(r.name, "intVector", 32'(r.expVector), 32'(intVector));
	endtask

	task automatic expectQuiet(input row_t r);
		for (int c = 0; c < QUIET_WINDOW; c++) begin
			@(negedge CLK);
			assert (intReq === 1'b0)
			else stopRun($sformatf("%s: unexpected interrupt request with vector %0d", r.name,
				intVector));
		end
	endtask

	task automatic runRow(input row_t r);
		apbData_t rdata;
		logic err;
		logic ready;
		@(negedge CLK);
		cpuMask = r.mask;
		case (r.act)
			ACT_WRITE, ACT_READ: begin
				apbTransfer(r.act == ACT_WRITE, r.target[3:0], r.data, rdata, err, ready);
				assert (ready === 1'b1)
				else stopRun($sformatf("%s: pready was low in the access cycle", r.name));
				assert (err === r.expErr)
				else reportMismatch(r.name, "pslverr", 32'(r.expErr), 32'(err));
				if (r.act == ACT_READ) begin
					assert (rdata === r.expData)
					else reportMismatch(r.name, "prdata", r.expData, rdata);
				end
			end
			ACT_PINS: begin
				nmiN = r.target[8];
				irqN = r.target[7:0];
			end
			default: begin
				intAck = 1'b1;
				@(negedge CLK);
				intAck = 1'b0;
			end
		endcase
		case (r.chk)
			CHK_REQ: expectRequest(r);
			CHK_QUIET: expectQuiet(r);
			default: repeat (4) @(negedge CLK);
		endcase
	endtask

	initial begin
		CLK = 1'b0;
		RST_N = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		nmiN = 1'b1;
		irqN = '1;
		cpuMask = '0;
		intAck = 1'b0;
		buildTable();
		repeat (3) @(negedge CLK);
		RST_N = 1'b1;
		assert (intReq === 1'b0 && intLevel === '0 && intVector === '0 && pslverr === 1'b0)
		else stopRun("outputs are not at their reset values after reset");
		foreach (rows[i]) begin
			runRow(rows[i]);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== compile.f ====
hdl/intcPkg.sv
hdl/nmiDetect.sv
hdl/irqFilter.sv
hdl/intcRegs.sv
hdl/intArbiter.sv
hdl/intcTop.sv
tests/intcTb.sv

// ==== Bender.yml ====
package:
  name: intc

dependencies: {}

sources:
  - files:
      - hdl/intcPkg.sv
      - hdl/nmiDetect.sv
      - hdl/irqFilter.sv
      - hdl/intcRegs.sv
      - hdl/intArbiter.sv
      - hdl/intcTop.sv
  - target: simulation
    files:
      - tests/intcTb.sv
